/* sources.f */
src/audio_pkg.sv
src/ir_pkg.sv
src/impulse_generator.sv
src/record_impulse.sv
src/ir_memory.sv
src/ir_capture_top.sv
sim/ir_capture_chk.sv
sim/ir_capture_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := ir_capture_tb
FILELIST   := sources.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/ir_capture_tb.sv */
`timescale 1ns/1ps

module ir_capture_tb;

    localparam int                 IR_LEN      = 48;
    localparam audio_pkg::sample_t CLICK_LEVEL = 16'sd16000;
    localparam int                 N_CAPTURES  = 4;
    localparam int                 MAX_DELAY   = 9;
    localparam int                 MAX_GAP     = 5;

    // Click steps, done step and one spare on top of delay and recording
    localparam int CAPTURE_STEPS  = MAX_DELAY + IR_LEN + 4;
    localparam int TIMEOUT_CYCLES = N_CAPTURES * (CAPTURE_STEPS * MAX_GAP + IR_LEN + 2) + 100;

    typedef logic [$clog2(IR_LEN)-1:0] slot_t;

    logic               audio_clk;
    logic               rst_in;
    logic               audio_trigger;
    logic               record_trigger;
    ir_pkg::index_t     delay_length;
    audio_pkg::sample_t audio_in;
    ir_pkg::index_t     read_addr;
    audio_pkg::sample_t impulse_amp_out;
    logic               impulse_recorded;
    logic               write_enable;
    ir_pkg::index_t     ir_sample_index;
    audio_pkg::sample_t read_data;

    logic [31:0]        lfsr;
    int                 cycle_count;
    int                 click_phase;       // 0 silent, 1 armed, 2 sounding
    logic               counting;
    int                 steps_after_click;
    int                 cur_delay;
    int                 captured;
    int                 prev_delay;
    int                 delay_pick;
    audio_pkg::sample_t exp_amp;
    logic               exp_we;
    logic               exp_done;
    ir_pkg::index_t     exp_idx;
    audio_pkg::sample_t exp_mem [IR_LEN];

    ir_capture_top #(
        .IR_LENGTH (IR_LEN),
        .CLICK_AMP (CLICK_LEVEL)
    ) u_dut (
        .audio_clk        (audio_clk),
        .rst_in           (rst_in),
        .audio_trigger    (audio_trigger),
        .record_trigger   (record_trigger),
        .delay_length     (delay_length),
        .audio_in         (audio_in),
        .read_addr        (read_addr),
        .impulse_amp_out  (impulse_amp_out),
        .impulse_recorded (impulse_recorded),
        .write_enable     (write_enable),
        .ir_sample_index  (ir_sample_index),
        .read_data        (read_data)
    );

    always #5 audio_clk = ~audio_clk;

    ////////////////////////////////////////
    // Failure reporting and timeout
    ////////////////////////////////////////

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic value_error(input string name, input int got, input int expected);
        $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
        stop_run();
    endtask

    task automatic plain_error(input string what);
        $display("%s", what);
        stop_run();
    endtask

    always @(posedge audio_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            plain_error($sformatf("Timeout: run went past %0d cycles", TIMEOUT_CYCLES));
        end
    end

    ////////////////////////////////////////
    // Stimulus source and reference model
    ////////////////////////////////////////

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int k = 0; k < count; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // Taps 32 22 2 1
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // Outputs expected after the coming rising edge
    task automatic predict_outputs(input logic step, input logic trig,
                                   input audio_pkg::sample_t sample);
        exp_done = 1'b0;
        if (counting && step) begin
            steps_after_click++;
            if (steps_after_click == cur_delay - 1) begin
                exp_we = 1'b1;                        // Window opens
            end else if (steps_after_click >= cur_delay
                         && steps_after_click < cur_delay + IR_LEN) begin
                exp_idx = ir_pkg::index_t'(steps_after_click - cur_delay);
                exp_mem[slot_t'(steps_after_click - cur_delay)] = sample;
            end else if (steps_after_click == cur_delay + IR_LEN) begin
                exp_we   = 1'b0;                      // Window closes with the done pulse
                exp_done = 1'b1;
                counting = 1'b0;
            end
        end
        case (click_phase)
            0: begin
                if (trig) begin
                    click_phase = 1;
                end
            end
            1: begin
                if (step) begin
                    exp_amp     = CLICK_LEVEL;
                    click_phase = 2;
                end
            end
            default: begin
                if (step) begin
                    exp_amp           = '0;           // Click over, delay count starts
                    click_phase       = 0;
                    counting          = 1'b1;
                    steps_after_click = 0;
                end
            end
        endcase
    endtask

    task automatic check_outputs();
        assert (impulse_amp_out == exp_amp)
            else value_error("impulse_amp_out", int'(impulse_amp_out), int'(exp_amp));
        assert (write_enable == exp_we)
            else value_error("write_enable", int'(write_enable), int'(exp_we));
        assert (impulse_recorded == exp_done)
            else value_error("impulse_recorded", int'(impulse_recorded), int'(exp_done));
        assert (ir_sample_index == exp_idx)
            else value_error("ir_sample_index", int'(ir_sample_index), int'(exp_idx));
    endtask

    ////////////////////////////////////////
    // Cycle level drivers
    ////////////////////////////////////////

    // Called at a falling edge, returns at the next one
    task automatic run_cycle(input logic step, input logic trig);
        audio_pkg::sample_t sample;
        sample = audio_in;
        if (step) begin
            sample = audio_pkg::sample_t'(rand_bits(16));
        end
        audio_trigger  = step;
        record_trigger = trig;
        audio_in       = sample;
        predict_outputs(step, trig, sample);
        @(negedge audio_clk);
        check_outputs();
        if (u_dut.ir_data_in_valid === 1'b1) begin
            captured++; // Memory write seen this cycle
        end
    endtask

    task automatic next_step();
        int gap;
        gap = 2 + int'(rand_bits(2)); // 2 to 5 cycles per sample
        repeat (gap - 1) run_cycle(1'b0, 1'b0);
        run_cycle(1'b1, 1'b0);
    endtask

    task automatic read_back();
        for (int a = 0; a < IR_LEN; a++) begin
            read_addr = ir_pkg::index_t'(a);
            run_cycle(1'b0, 1'b0);
            assert (read_data == exp_mem[slot_t'(a)])
                else value_error($sformatf("read_data[%0d]", a), int'(read_data),
                                 int'(exp_mem[slot_t'(a)]));
        end
    endtask

    task automatic run_capture(input int delay_steps);
        cur_delay    = delay_steps;
        captured     = 0;
        delay_length = ir_pkg::index_t'(delay_steps);
        run_cycle(1'b0, 1'b1);
        while (impulse_recorded !== 1'b1) begin
            next_step();
        end
        assert (captured == IR_LEN)
            else value_error("ir_data_in_valid pulses", captured, IR_LEN);
        read_back();
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        audio_clk         = 1'b0;
        rst_in            = 1'b1;
        audio_trigger     = 1'b0;
        record_trigger    = 1'b0;
        delay_length      = ir_pkg::index_t'(2);
        audio_in          = '0;
        read_addr         = '0;
        lfsr              = 32'h17b0;
        cycle_count       = 0;
        click_phase       = 0;
        counting          = 1'b0;
        steps_after_click = 0;
        cur_delay         = 2;
        captured          = 0;
        prev_delay        = 0;
        exp_amp           = '0;
        exp_we            = 1'b0;
        exp_done          = 1'b0;
        exp_idx           = '0;

        repeat (4) @(negedge audio_clk);
        rst_in = 1'b0;
        check_outputs(); // Idle state straight out of reset

        for (int n = 0; n < N_CAPTURES; n++) begin
            delay_pick = 2 + int'(rand_bits(3));
            if (delay_pick == prev_delay) begin
                delay_pick = (delay_pick == MAX_DELAY) ? 2 : delay_pick + 1;
            end
            prev_delay = delay_pick;
            run_capture(delay_pick);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* sim/ir_capture_chk.sv */
`timescale 1ns/1ps

module ir_capture_chk (
    input logic audio_clk,
    input logic rst_in,
    input logic write_enable,
    input logic ir_data_in_valid,
    input logic impulse_recorded
);

    ////////////////////////////////////////
    // Recorder control rules
    ////////////////////////////////////////

    // Memory writes only inside the capture window
    a_write_in_window: assert property (
        @(posedge audio_clk) disable iff (rst_in)
        ir_data_in_valid |-> write_enable
    ) else $error("write strobe outside the capture window");

    a_done_one_cycle: assert property (
        @(posedge audio_clk) disable iff (rst_in)
        impulse_recorded |=> !impulse_recorded
    ) else $error("impulse_recorded held longer than one cycle");

    a_write_one_cycle: assert property (
        @(posedge audio_clk) disable iff (rst_in)
        ir_data_in_valid |=> !ir_data_in_valid
    ) else $error("ir_data_in_valid held longer than one cycle");

    // Window only closes at the end of a capture
    a_window_close: assert property (
        @(posedge audio_clk) disable iff (rst_in)
        $fell(write_enable) |-> impulse_recorded
    ) else $error("write_enable fell without the done pulse");

endmodule

bind record_impulse ir_capture_chk u_chk (
    .audio_clk        (audio_clk),
    .rst_in           (rst_in),
    .write_enable     (write_enable),
    .ir_data_in_valid (ir_data_in_valid),
    .impulse_recorded (impulse_recorded)
);

/* src/ir_capture_top.sv */
`timescale 1ns/1ps

module ir_capture_top #(
    parameter int                 IR_LENGTH = 24000,
    parameter audio_pkg::sample_t CLICK_AMP = 16'sd16000
) (
    input  logic               audio_clk,
    input  logic               rst_in,
    input  logic               audio_trigger,
    input  logic               record_trigger,
    input  ir_pkg::index_t     delay_length,
    input  audio_pkg::sample_t audio_in,
    input  ir_pkg::index_t     read_addr,
    output audio_pkg::sample_t impulse_amp_out,
    output logic               impulse_recorded,
    output logic               write_enable,
    output ir_pkg::index_t     ir_sample_index,
    output audio_pkg::sample_t read_data
);

    logic               ir_data_in_valid;
    audio_pkg::sample_t write_data;

    ////////////////////////////////////////
    // Capture control
    ////////////////////////////////////////

    record_impulse #(
        .IR_LENGTH (IR_LENGTH),
        .CLICK_AMP (CLICK_AMP)
    ) u_recorder (
        .audio_clk              (audio_clk),
        .rst_in                 (rst_in),
        .audio_trigger          (audio_trigger),
        .record_impulse_trigger (record_trigger),
        .delay_length           (delay_length),
        .audio_in               (audio_in),
        .impulse_recorded       (impulse_recorded),
        .write_enable           (write_enable),
        .ir_data_in_valid       (ir_data_in_valid),
        .ir_sample_index        (ir_sample_index),
        .write_data             (write_data),
        .impulse_amp_out        (impulse_amp_out)
    );

    ////////////////////////////////////////
    // Impulse response storage
    ////////////////////////////////////////

    ir_memory #(
        .IR_LENGTH (IR_LENGTH)
    ) u_ir_mem (
        .audio_clk    (audio_clk),
        .write_strobe (ir_data_in_valid),
        .write_addr   (ir_sample_index), // Index of the current write
        .read_addr    (read_addr),
        .write_data   (write_data),
        .read_data    (read_data)        // Convolution side
    );

endmodule

/* src/ir_memory.sv */
`timescale 1ns/1ps

module ir_memory #(
    parameter int IR_LENGTH = 24000
) (
    input  logic               audio_clk,
    input  logic               write_strobe,
    input  ir_pkg::index_t     write_addr,
    input  ir_pkg::index_t     read_addr,
    input  audio_pkg::sample_t write_data,
    output audio_pkg::sample_t read_data
);

    // Address bits actually decoded for this depth
    localparam int ADDR_W = (IR_LENGTH > 1) ? $clog2(IR_LENGTH) : 1;

    audio_pkg::sample_t mem [IR_LENGTH];

    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    assign wr_addr = write_addr[ADDR_W-1:0];
    assign rd_addr = read_addr[ADDR_W-1:0];

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    // The recorder qualifies the strobe with its capture window
    always_ff @(posedge audio_clk) begin
        if (write_strobe) begin
            mem[wr_addr] <= write_data;
        end
    end

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////

    // Registered output so the array maps onto block RAM; the
    // convolution stage sees data one cycle after it presents an address
    always_ff @(posedge audio_clk) begin
        read_data <= mem[rd_addr];
    end

endmodule

/* src/record_impulse.sv */
`timescale 1ns/1ps

module record_impulse #(
    parameter int                 IR_LENGTH = 24000,
    parameter audio_pkg::sample_t CLICK_AMP = 16'sd16000
) (
    input  logic               audio_clk,
    input  logic               rst_in,
    input  logic               audio_trigger,
    input  logic               record_impulse_trigger,
    input  ir_pkg::index_t     delay_length,
    input  audio_pkg::sample_t audio_in,
    output logic               impulse_recorded,
    output logic               write_enable,
    output logic               ir_data_in_valid,
    output ir_pkg::index_t     ir_sample_index,
    output audio_pkg::sample_t write_data,
    output audio_pkg::sample_t impulse_amp_out
);

    localparam ir_pkg::index_t LAST_COUNT = ir_pkg::index_t'(IR_LENGTH);

    ir_pkg::record_state_e state;
    ir_pkg::index_t        delayed_so_far;
    ir_pkg::index_t        recorded_so_far;
    logic                  impulse_completed;
    logic                  capture_step;

    ////////////////////////////////////////
    // Click source
    ////////////////////////////////////////

    impulse_generator #(
        .CLICK_AMP (CLICK_AMP)
    ) u_click (
        .audio_clk   (audio_clk),
        .rst_in      (rst_in),
        .step_in     (audio_trigger),
        .impulse_in  (record_impulse_trigger),
        .impulse_out (impulse_completed),
        .amp_out     (impulse_amp_out)
    );

    // A step inside the capture window that still has a sample to take
    assign capture_step = (state == ir_pkg::RECORDING) && audio_trigger
                          && (recorded_so_far != LAST_COUNT);

    ////////////////////////////////////////
    // Capture FSM
    ////////////////////////////////////////

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state            <= ir_pkg::WAITING_FOR_IMPULSE;
            delayed_so_far   <= '0;
            recorded_so_far  <= '0;
            impulse_recorded <= 1'b0;
            write_enable     <= 1'b0;
            ir_data_in_valid <= 1'b0;
            ir_sample_index  <= '0;
        end else begin
            impulse_recorded <= 1'b0; // Pulses default low
            ir_data_in_valid <= 1'b0;

            case (state)
                ir_pkg::WAITING_FOR_IMPULSE: begin
                    write_enable    <= 1'b0;
                    recorded_so_far <= '0;
                    if (impulse_completed) begin
                        delayed_so_far <= ir_pkg::index_t'(1);
                        state          <= ir_pkg::DELAYING;
                    end
                end

                // Counts steps after the click has died away so the room
                // response starts inside the window, not the direct sound
                ir_pkg::DELAYING: begin
                    if (audio_trigger) begin
                        if (delayed_so_far == delay_length - 1'b1) begin
                            write_enable <= 1'b1;
                            state        <= ir_pkg::RECORDING;
                        end else begin
                            delayed_so_far <= delayed_so_far + 1'b1;
                        end
                    end
                end

                ir_pkg::RECORDING: begin
                    if (capture_step) begin
                        ir_sample_index  <= recorded_so_far;
                        ir_data_in_valid <= 1'b1;              // Write lands next cycle
                        recorded_so_far  <= recorded_so_far + 1'b1;
                    end else if (audio_trigger) begin
                        write_enable     <= 1'b0;              // Window closes, no write
                        impulse_recorded <= 1'b1;
                        state            <= ir_pkg::WAITING_FOR_IMPULSE;
                    end
                end

                default: begin
                    write_enable <= 1'b0;
                    state        <= ir_pkg::WAITING_FOR_IMPULSE;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Sample register
    ////////////////////////////////////////

    always_ff @(posedge audio_clk) begin
        if (capture_step) begin
            write_data <= audio_in; // Mic sample for this index
        end
    end

endmodule

/* src/impulse_generator.sv */
`timescale 1ns/1ps

module impulse_generator #(
    parameter audio_pkg::sample_t CLICK_AMP = 16'sd16000
) (
    input  logic               audio_clk,
    input  logic               rst_in,
    input  logic               step_in,
    input  logic               impulse_in,
    output logic               impulse_out,
    output audio_pkg::sample_t amp_out
);

    ir_pkg::click_state_e state;

    ////////////////////////////////////////
    // Click sequencer
    ////////////////////////////////////////

    // The click is a single full sample period at CLICK_AMP, so the
    // speaker sees one discrete impulse and then silence. Completion is
    // reported only once the output is back at zero.
    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state       <= ir_pkg::IDLE;
            impulse_out <= 1'b0;
            amp_out     <= audio_pkg::SILENCE;
        end else begin
            impulse_out <= 1'b0; // Single cycle pulse

            case (state)
                ir_pkg::IDLE: begin
                    amp_out <= audio_pkg::SILENCE;
                    if (impulse_in) begin
                        state <= ir_pkg::ARMED;
                    end
                end

                ir_pkg::ARMED: begin
                    if (step_in) begin
                        amp_out <= CLICK_AMP; // Start of the click sample
                        state   <= ir_pkg::SOUNDING;
                    end
                end

                ir_pkg::SOUNDING: begin
                    if (step_in) begin
                        amp_out     <= audio_pkg::SILENCE;
                        impulse_out <= 1'b1; // Click done, output silent
                        state       <= ir_pkg::IDLE;
                    end
                end

                default: begin
                    amp_out <= audio_pkg::SILENCE;
                    state   <= ir_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

/* src/ir_pkg.sv */
package ir_pkg;

    ////////////////////////////////////////
    // Capture indexing
    ////////////////////////////////////////

    // Covers delay counts, sample counts and memory addresses
    parameter int INDEX_W = 16;

    typedef logic [INDEX_W-1:0] index_t;

    ////////////////////////////////////////
    // Control state encodings
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        WAITING_FOR_IMPULSE = 2'd0, // Idle until the click has been played
        DELAYING            = 2'd1, // Counting the post-click gap
        RECORDING           = 2'd2  // Writing microphone samples
    } record_state_e;

    typedef enum logic [1:0] {
        IDLE     = 2'd0, // Output silent, waiting for a trigger
        ARMED    = 2'd1, // Click starts on the next step
        SOUNDING = 2'd2  // Click on the output for one step
    } click_state_e;

endpackage

/* src/audio_pkg.sv */
package audio_pkg;

    ////////////////////////////////////////
    // Audio sample format
    ////////////////////////////////////////

    // Codec word width, shared by mic and speaker paths
    parameter int SAMPLE_W = 16;

    // Two's complement PCM sample
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // Digital silence on the output
    parameter sample_t SILENCE = '0;

endpackage
